/* hw/fm_pkg.sv */
// shared widths, word types, init fill pattern and init FSM states for the spy buffer array
package fm_pkg;

	// sample and spy word
	localparam int spy_word_w = 32;                    // monitored sample width
	typedef logic [spy_word_w-1:0] spy_word_t;         // one sample or one spy word

	// spy memory geometry
	localparam int spy_addr_w = 6;                     // address bits per channel
	typedef logic [spy_addr_w-1:0] spy_addr_t;         // spy address or write pointer
	localparam int spy_depth = 1 << spy_addr_w;        // 64 words per channel

	// word the init sweep leaves in every location
	localparam spy_word_t spy_fill_pattern = 32'h0fa5fa50;

	// init sweep control
	// the sweep state is also what the access block sees
	typedef enum logic
	{
		init_idle,                                     // processor owns the spy ports
		init_sweep                                     // fill pattern is being written
	} init_state_t;

endpackage

/* hw/fm_spy_if.sv */
// spy access port of one channel, driven by the access mux and served by the channel buffer
`timescale 1ns/10ps

interface fm_spy_if
	import fm_pkg::*;
	();

	logic      spy_en;                             // port enable, read on every enabled edge
	logic      spy_wr_en;                          // write strobe, only with spy_en
	spy_addr_t spy_addr;                           // word address inside the channel
	spy_word_t spy_wr_data;                        // word to write
	spy_word_t spy_rd_data;                        // old word at spy_addr, one edge later

	// access side drives the request
	modport access
	(
		output spy_en,
		output spy_wr_en,
		output spy_addr,
		output spy_wr_data,
		input  spy_rd_data
	);

	// buffer side serves the memory
	modport buffer
	(
		input  spy_en,
		input  spy_wr_en,
		input  spy_addr,
		input  spy_wr_data,
		output spy_rd_data
	);

endinterface

/* hw/fm_spy_mem.sv */
// spy memory of one channel with a capture write port and a registered spy read/write port
`timescale 1ns/10ps

module fm_spy_mem
	import fm_pkg::*;
(
	input  logic      spy_clock,
	input  logic      cap_wr_en_i,                 // capture write strobe
	input  spy_addr_t cap_addr_i,                  // capture write pointer
	input  spy_word_t cap_data_i,                  // captured sample
	input  logic      spy_en_i,                    // spy port enable
	input  logic      spy_wr_en_i,                 // spy write strobe
	input  spy_addr_t spy_addr_i,                  // spy word address
	input  spy_word_t spy_wr_data_i,               // spy write word
	output spy_word_t spy_rd_data_o                // registered spy read word
);

	spy_word_t mem [spy_depth];                    // spy words of this channel
	logic      spy_write;                          // spy port writes this edge
	logic      cap_write;                          // capture write that survives a collision

	assign spy_write = spy_en_i & spy_wr_en_i;
	// spy write takes the slot when both ports aim at one address
	assign cap_write = cap_wr_en_i & ~(spy_write & (spy_addr_i == cap_addr_i));

	always_ff @(posedge spy_clock)
	begin
		if (cap_write)
		begin
			mem[cap_addr_i] <= cap_data_i;             // circular capture
		end
		if (spy_write)
		begin
			mem[spy_addr_i] <= spy_wr_data_i;          // processor or init write
		end
	end

	// read before write on the spy port
	always_ff @(posedge spy_clock)
	begin
		if (spy_en_i)
		begin
			spy_rd_data_o <= mem[spy_addr_i];          // old contents on a write
		end
	end

endmodule

/* hw/fm_spy_buffer.sv */
// one monitored channel with circular capture, freeze, passthrough register and spy memory
`timescale 1ns/10ps

module fm_spy_buffer
	import fm_pkg::*;
(
	input  logic      spy_clock,
	input  logic      axi_reset_n,                 // sync, active low
	input  logic      chan_reset_i,                // per-channel restart of the pointer
	input  spy_word_t mon_data_i,                  // monitored sample
	input  logic      mon_vld_i,                   // sample valid
	input  logic      freeze_i,                    // hold memory contents
	fm_spy_if.buffer  spy,                         // spy access from the mux
	output spy_word_t playback_data_o,             // sample delayed one cycle
	output logic      playback_vld_o               // valid delayed one cycle
);

	spy_addr_t wr_ptr;                             // next capture slot
	logic      cap_en;                             // sample goes into memory
	logic      clr;                                // either reset

	assign cap_en = mon_vld_i & ~freeze_i;         // frozen channel keeps its words
	assign clr    = ~axi_reset_n | chan_reset_i;

	// write pointer wraps at spy_depth through the address width
	always_ff @(posedge spy_clock)
	begin
		if (clr)
		begin
			wr_ptr <= '0;
		end
		else if (cap_en)
		begin
			wr_ptr <= wr_ptr + 1'b1;                   // modulo 64
		end
	end

	// passthrough stage runs whether frozen or not
	always_ff @(posedge spy_clock)
	begin
		if (clr)
		begin
			playback_vld_o <= 1'b0;
		end
		else
		begin
			playback_vld_o <= mon_vld_i;
		end
	end

	always_ff @(posedge spy_clock)
	begin
		playback_data_o <= mon_data_i;             // sample copy for playback
	end

	fm_spy_mem i_spy_mem
	(
		.spy_clock     (spy_clock),
		.cap_wr_en_i   (cap_en),
		.cap_addr_i    (wr_ptr),
		.cap_data_i    (mon_data_i),
		.spy_en_i      (spy.spy_en),
		.spy_wr_en_i   (spy.spy_wr_en),
		.spy_addr_i    (spy.spy_addr),
		.spy_wr_data_i (spy.spy_wr_data),
		.spy_rd_data_o (spy.spy_rd_data)
	);

endmodule

/* hw/fm_spy_init.sv */
// init sweep FSM that walks one address over every spy memory word while the request is held
`timescale 1ns/10ps

module fm_spy_init
	import fm_pkg::*;
(
	input  logic        spy_clock,
	input  logic        axi_reset_n,               // sync, active low
	input  logic        init_spy_mem_i,            // sweep request level
	output init_state_t init_active_o,             // sweep state seen by the access mux
	output spy_addr_t   init_addr_o                // word being filled
);

	init_state_t state;
	init_state_t state_next;

	// state is the registered request
	always_comb
	begin
		state_next = state;
		case (state)
			init_idle:
				if (init_spy_mem_i)
					state_next = init_sweep;
			init_sweep:
				if (!init_spy_mem_i)
					state_next = init_idle;
			default:
				state_next = init_idle;
		endcase
	end

	always_ff @(posedge spy_clock)
	begin
		if (!axi_reset_n)
		begin
			state       <= init_sweep;                 // one sweep cycle after reset fills word 0
			init_addr_o <= '0;
		end
		else
		begin
			state <= state_next;
			if (state == init_sweep)
				init_addr_o <= init_addr_o + 1'b1;     // wraps over the depth
			else
				init_addr_o <= '0;                     // next sweep starts at word 0
		end
	end

	assign init_active_o = state;

endmodule

/* hw/fm_spy_access.sv */
// per-channel mux between processor spy access and init fill, with read valid and data gating
`timescale 1ns/10ps

module fm_spy_access
	import fm_pkg::*;
#(
	parameter int n_channels = 4
)
(
	input  logic                  spy_clock,
	input  logic                  axi_reset_n,            // sync, active low
	input  init_state_t           init_active_i,          // sweep state from the init FSM
	input  spy_addr_t             init_addr_i,            // fill address, same for all channels
	input  logic [n_channels-1:0] spy_en_i,               // processor read enables
	input  logic [n_channels-1:0] spy_wr_en_i,            // processor write strobes
	input  spy_addr_t             spy_addr_i [n_channels],
	input  spy_word_t             spy_wr_data_i [n_channels],
	fm_spy_if.access              spy [n_channels],       // one port per channel
	output spy_word_t             spy_rd_data_o [n_channels],
	output logic [n_channels-1:0] spy_rd_vld_o            // one edge after a read enable
);

	logic sweep_on;                                // init owns every spy port

	assign sweep_on = (init_active_i == init_sweep);

	for (genvar g = 0; g < n_channels; g++)
	begin : g_chan
		// sweep forces a pattern write, processor requests dropped meanwhile
		assign spy[g].spy_en      = sweep_on | spy_en_i[g] | spy_wr_en_i[g];
		assign spy[g].spy_wr_en   = sweep_on | spy_wr_en_i[g];
		assign spy[g].spy_addr    = sweep_on ? init_addr_i : spy_addr_i[g];
		assign spy[g].spy_wr_data = sweep_on ? spy_fill_pattern : spy_wr_data_i[g];

		// data is zero unless a read was issued the cycle before
		assign spy_rd_data_o[g]   = spy_rd_vld_o[g] ? spy[g].spy_rd_data : '0;
	end

	// valid only for outside reads issued with no sweep running
	always_ff @(posedge spy_clock)
	begin
		if (!axi_reset_n)
		begin
			spy_rd_vld_o <= '0;
		end
		else if (sweep_on)
		begin
			spy_rd_vld_o <= '0;                        // init writes return no data
		end
		else
		begin
			spy_rd_vld_o <= spy_en_i;
		end
	end

endmodule

/* hw/fm_data.sv */
// top level of the spy buffer array, ties the channel buffers to the access mux and init sweep
`timescale 1ns/10ps

module fm_data
	import fm_pkg::*;
#(
	parameter int n_channels = 4                   // any count from 1 up
)
(
	input  logic                  spy_clock,
	input  logic                  axi_reset_n,            // sync, active low
	input  spy_word_t             mon_data_i [n_channels],
	input  logic [n_channels-1:0] mon_vld_i,
	input  logic [n_channels-1:0] freeze_i,               // stop capture per channel
	input  logic [n_channels-1:0] sb_reset_i,             // restart write pointer per channel
	input  logic                  init_spy_mem_i,         // fill request, held for the sweep
	input  logic [n_channels-1:0] spy_en_i,
	input  logic [n_channels-1:0] spy_wr_en_i,
	input  spy_addr_t             spy_addr_i [n_channels],
	input  spy_word_t             spy_wr_data_i [n_channels],
	output spy_word_t             spy_rd_data_o [n_channels],
	output logic [n_channels-1:0] spy_rd_vld_o,
	output spy_word_t             playback_data_o [n_channels],
	output logic [n_channels-1:0] playback_vld_o
);

	init_state_t init_active;                      // sweep state to the mux
	spy_addr_t   init_addr;                        // fill address to the mux

	fm_spy_if spy_bus [n_channels] ();             // mux to buffer, one per channel

	fm_spy_init i_spy_init
	(
		.spy_clock      (spy_clock),
		.axi_reset_n    (axi_reset_n),
		.init_spy_mem_i (init_spy_mem_i),
		.init_active_o  (init_active),
		.init_addr_o    (init_addr)
	);

	fm_spy_access #(
		.n_channels (n_channels)
	) i_spy_access
	(
		.spy_clock     (spy_clock),
		.axi_reset_n   (axi_reset_n),
		.init_active_i (init_active),
		.init_addr_i   (init_addr),
		.spy_en_i      (spy_en_i),
		.spy_wr_en_i   (spy_wr_en_i),
		.spy_addr_i    (spy_addr_i),
		.spy_wr_data_i (spy_wr_data_i),
		.spy           (spy_bus),
		.spy_rd_data_o (spy_rd_data_o),
		.spy_rd_vld_o  (spy_rd_vld_o)
	);

	for (genvar g = 0; g < n_channels; g++)
	begin : g_buf
		fm_spy_buffer i_spy_buffer
		(
			.spy_clock       (spy_clock),
			.axi_reset_n     (axi_reset_n),
			.chan_reset_i    (sb_reset_i[g]),
			.mon_data_i      (mon_data_i[g]),
			.mon_vld_i       (mon_vld_i[g]),
			.freeze_i        (freeze_i[g]),
			.spy             (spy_bus[g]),
			.playback_data_o (playback_data_o[g]),
			.playback_vld_o  (playback_vld_o[g])
		);
	end

endmodule

/* verification/fm_data_ref.svh */
// reference model of the spy memories and write pointers, included into the testbench module body

localparam spy_word_t fill_word = 32'h0fa5fa50;   // word left by the init sweep
localparam int words = 64;                        // words per channel

spy_word_t shadow [n_ch][words];                  // expected memory contents
int        ptr_m [n_ch];                          // expected capture pointers

// sample lands at the pointer, pointer wraps after the last word
function automatic void exp_capture(input int ch, input spy_word_t data, input logic take);
	if (take)
	begin
		shadow[ch][ptr_m[ch]] = data;
		ptr_m[ch] = (ptr_m[ch] + 1) % words;
	end
endfunction

// called after exp_capture so a spy write wins a shared address
function automatic void exp_spy_write(input int ch, input int addr, input spy_word_t data);
	shadow[ch][addr] = data;
endfunction

// one sweep step writes the same address in every channel
function automatic void exp_init(input int addr);
	for (int c = 0; c < n_ch; c++)
		shadow[c][addr] = fill_word;
endfunction

// contents before the edge that serves the read
function automatic spy_word_t exp_read(input int ch, input int addr);
	return shadow[ch][addr];
endfunction

function automatic void restart_pointer(input int ch);
	ptr_m[ch] = 0;                                // axi or channel reset
endfunction

/* verification/fm_data_tb.sv */
// self-checking testbench for fm_data that runs from list.f with fm_data_tb as top
`timescale 1ns/10ps

module fm_data_tb
	import fm_pkg::*;
	();

	localparam int n_ch = 4;

	// the timeout is twice the summed phase lengths in cycles
	localparam int reset_len   = 16;
	localparam int init_len    = 72;
	localparam int read_len    = 66;
	localparam int capture_len = 200;
	localparam int freeze_len  = 30;
	localparam int write_len   = 40;
	localparam int chreset_len = 16;
	localparam int traffic_len = 60;
	localparam int cycle_limit = 2 * (reset_len + init_len + capture_len + freeze_len
		+ write_len + chreset_len + traffic_len + 5 * read_len);

	`include "fm_data_ref.svh"

	logic              spy_clock = 1'b0;
	logic              axi_reset_n;
	spy_word_t         mon_data_i [n_ch];
	logic [n_ch-1:0]   mon_vld_i;
	logic [n_ch-1:0]   freeze_i;
	logic [n_ch-1:0]   sb_reset_i;
	logic              init_spy_mem_i;
	logic [n_ch-1:0]   spy_en_i;
	logic [n_ch-1:0]   spy_wr_en_i;
	spy_addr_t         spy_addr_i [n_ch];
	spy_word_t         spy_wr_data_i [n_ch];
	spy_word_t         spy_rd_data_o [n_ch];
	logic [n_ch-1:0]   spy_rd_vld_o;
	spy_word_t         playback_data_o [n_ch];
	logic [n_ch-1:0]   playback_vld_o;

	integer    seed;
	string     test_name = "reset";
	int        rd_errs = 0;                       // spy read mismatches
	int        pb_errs = 0;                       // playback mismatches
	int        cycles = 0;
	logic      have_prev = 1'b0;                  // first negedge has nothing to check
	logic      sweep_cur = 1'b1;                  // modelled init state of this cycle
	int        init_addr_m = 0;                   // modelled sweep address
	logic [n_ch-1:0] exp_rd_vld;
	spy_word_t       exp_rd_data [n_ch];
	logic [n_ch-1:0] exp_pb_vld;
	spy_word_t       exp_pb_data [n_ch];

	always #10 spy_clock = ~spy_clock;            // 20 ns period

	fm_data #(
		.n_channels (n_ch)
	) i_dut
	(
		.spy_clock       (spy_clock),
		.axi_reset_n     (axi_reset_n),
		.mon_data_i      (mon_data_i),
		.mon_vld_i       (mon_vld_i),
		.freeze_i        (freeze_i),
		.sb_reset_i      (sb_reset_i),
		.init_spy_mem_i  (init_spy_mem_i),
		.spy_en_i        (spy_en_i),
		.spy_wr_en_i     (spy_wr_en_i),
		.spy_addr_i      (spy_addr_i),
		.spy_wr_data_i   (spy_wr_data_i),
		.spy_rd_data_o   (spy_rd_data_o),
		.spy_rd_vld_o    (spy_rd_vld_o),
		.playback_data_o (playback_data_o),
		.playback_vld_o  (playback_vld_o)
	);

	// compare at the falling edge and then model the coming rising edge
	always @(negedge spy_clock)
	begin
		for (int c = 0; c < n_ch; c++)
		begin
			if (have_prev)
			begin
				assert (spy_rd_vld_o[c] === exp_rd_vld[c])
				else
				begin
					$display("Error %s: ch%0d spy_rd_vld_o expected %b, actual %b",
						test_name, c, exp_rd_vld[c], spy_rd_vld_o[c]);
					rd_errs++;
				end
				assert (spy_rd_data_o[c] === exp_rd_data[c])
				else
				begin
					$display("Error %s: ch%0d spy_rd_data_o expected %h, actual %h",
						test_name, c, exp_rd_data[c], spy_rd_data_o[c]);
					rd_errs++;
				end
				assert (playback_vld_o[c] === exp_pb_vld[c] &&
					playback_data_o[c] === exp_pb_data[c])
				else
				begin
					$display("Error %s: ch%0d playback expected %b/%h, actual %b/%h",
						test_name, c, exp_pb_vld[c], exp_pb_data[c],
						playback_vld_o[c], playback_data_o[c]);
					pb_errs++;
				end
			end
			// reads are gated while the sweep owns the port
			exp_rd_vld[c]  = axi_reset_n & spy_en_i[c] & ~sweep_cur;
			exp_rd_data[c] = exp_rd_vld[c] ? exp_read(c, spy_addr_i[c]) : '0;
			exp_pb_vld[c]  = axi_reset_n & ~sb_reset_i[c] & mon_vld_i[c];
			exp_pb_data[c] = mon_data_i[c];
			if (!axi_reset_n || sb_reset_i[c])
				restart_pointer(c);
			else
				exp_capture(c, mon_data_i[c], mon_vld_i[c] & ~freeze_i[c]);
			if (!sweep_cur && spy_wr_en_i[c])
				exp_spy_write(c, spy_addr_i[c], spy_wr_data_i[c]);
		end
		if (sweep_cur)
			exp_init(init_addr_m);                    // overrides capture on a shared address
		init_addr_m = (axi_reset_n && sweep_cur) ? (init_addr_m + 1) % words : 0;
		sweep_cur   = ~axi_reset_n | init_spy_mem_i;  // request is registered
		have_prev   = 1'b1;
	end

	always @(posedge spy_clock)
	begin
		cycles++;
		if (cycles >= cycle_limit)
		begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Something failed");
			$finish;
		end
	end

	// one read per address on all channels in parallel
	task automatic read_all_words();
		for (int a = 0; a < words; a++)
		begin
			@(posedge spy_clock);
			spy_en_i <= '1;
			for (int c = 0; c < n_ch; c++)
				spy_addr_i[c] <= a;
		end
		@(posedge spy_clock);
		spy_en_i <= '0;
	endtask

	// random samples with gaps until every channel had the given count
	task automatic capture_random(input int samples);
		int   count [n_ch];
		logic busy;
		foreach (count[c])
			count[c] = 0;
		busy = 1'b1;
		while (busy)
		begin
			@(posedge spy_clock);
			busy = 1'b0;
			for (int c = 0; c < n_ch; c++)
			begin
				if (count[c] < samples && ($random(seed) & 3) != 0)
				begin
					mon_vld_i[c]  <= 1'b1;
					mon_data_i[c] <= $random(seed);
					count[c]++;
				end
				else
					mon_vld_i[c] <= 1'b0;        // gap
				if (count[c] < samples)
					busy = 1'b1;
			end
		end
		@(posedge spy_clock);
		mon_vld_i <= '0;
	endtask

	initial
	begin
		seed           = 5;
		axi_reset_n    <= 1'b0;
		mon_vld_i      <= '0;
		freeze_i       <= '0;
		sb_reset_i     <= '0;
		init_spy_mem_i <= 1'b0;
		spy_en_i       <= '0;
		spy_wr_en_i    <= '0;
		for (int c = 0; c < n_ch; c++)
		begin
			mon_data_i[c]    <= '0;
			spy_addr_i[c]    <= '0;
			spy_wr_data_i[c] <= '0;
		end
		repeat (reset_len) @(posedge spy_clock);
		axi_reset_n <= 1'b1;
		repeat (3) @(posedge spy_clock);

		test_name = "init_sweep";
		init_spy_mem_i <= 1'b1;
		for (int i = 0; i < 64; i++)
		begin
			@(posedge spy_clock);
			spy_en_i <= (i % 16 == 5) ? '1 : '0;      // must stay unanswered
		end
		init_spy_mem_i <= 1'b0;
		spy_en_i       <= '0;
		repeat (2) @(posedge spy_clock);
		read_all_words();

		test_name = "capture_wrap";
		capture_random(80);                         // 16 slots overwritten
		freeze_i <= '1;
		read_all_words();

		test_name = "freeze";
		freeze_i <= 4'b0010;                        // only channel 1 frozen
		capture_random(10);
		freeze_i <= 4'b1101;                        // channel 1 resumes at its held pointer
		capture_random(3);
		freeze_i <= '1;
		read_all_words();

		test_name = "spy_write";
		for (int i = 0; i < 8; i++)
		begin
			@(posedge spy_clock);
			spy_wr_en_i <= '1;
			for (int c = 0; c < n_ch; c++)
			begin
				spy_addr_i[c]    <= i * 8 + c;
				spy_wr_data_i[c] <= 32'hc0de0000 | (c << 8) | (i * 8 + c);
			end
		end
		@(posedge spy_clock);
		spy_wr_en_i <= '0;
		@(posedge spy_clock);
		freeze_i[0]      <= 1'b0;                   // capture and spy write hit the same slot
		mon_vld_i[0]     <= 1'b1;
		mon_data_i[0]    <= $random(seed);
		spy_wr_en_i[0]   <= 1'b1;
		spy_addr_i[0]    <= ptr_m[0];
		spy_wr_data_i[0] <= 32'h5a5a5a5a;
		@(posedge spy_clock);
		freeze_i    <= '1;
		mon_vld_i   <= '0;
		spy_wr_en_i <= '0;
		read_all_words();

		test_name = "chan_reset";
		@(posedge spy_clock);
		freeze_i      <= 4'b1011;                   // channel 2 captures alone
		sb_reset_i[2] <= 1'b1;
		@(posedge spy_clock);
		sb_reset_i[2] <= 1'b0;
		capture_random(5);
		freeze_i <= '1;
		read_all_words();

		test_name = "passthrough";
		freeze_i <= '0;
		repeat (traffic_len - 10)
		begin
			@(posedge spy_clock);
			for (int c = 0; c < n_ch; c++)
			begin
				mon_vld_i[c]  <= ($random(seed) & 1) != 0;
				mon_data_i[c] <= $random(seed);
				spy_en_i[c]   <= ($random(seed) & 3) == 0;  // sparse reads
				spy_addr_i[c] <= $random(seed) & 63;
			end
		end
		@(posedge spy_clock);
		mon_vld_i <= '0;
		spy_en_i  <= '0;
		repeat (4) @(posedge spy_clock);

		$display("errors: spy read %0d, playback %0d", rd_errs, pb_errs);
		if (rd_errs == 0 && pb_errs == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* list.f */
+incdir+verification
hw/fm_pkg.sv
hw/fm_spy_if.sv
hw/fm_spy_mem.sv
hw/fm_spy_buffer.sv
hw/fm_spy_init.sv
hw/fm_spy_access.sv
hw/fm_data.sv
verification/fm_data_tb.sv

/* Bender.yml */
package:
  name: fm_data

sources:
  - files:
      - hw/fm_pkg.sv
      - hw/fm_spy_if.sv
      - hw/fm_spy_mem.sv
      - hw/fm_spy_buffer.sv
      - hw/fm_spy_init.sv
      - hw/fm_spy_access.sv
      - hw/fm_data.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/fm_data_tb.sv
